// ==== timer_savestate_top.f ====
src/ss_timer_pkg.sv
src/clock_prescaler.sv
src/prog_timer.sv
src/interrupt_collector.sv
src/timer_savestate_top.sv
tests/timer_savestate_tb.sv

// ==== Makefile ====
# Verilator simulation of the timer block with its save-state bus

VERILATOR ?= verilator
TOP       ?= timer_savestate_tb
FILELIST  ?= timer_savestate_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/timer_savestate_tb.sv ====
`timescale 1ns/1ps

module timer_savestate_tb;

    localparam int NUM_TIMERS     = 4;
    localparam int RESET_CYCLES   = 3;
    localparam int NUM_MAPPED     = NUM_TIMERS + 2;
    localparam int READ_SWEEP     = 8;
    localparam int UNMAPPED_TRIES = 8;
    localparam int SEG_LEN        = 400;
    localparam int NUM_SEG        = 6;
    localparam int MARGIN         = 200;
    localparam int MAX_CYCLES     = RESET_CYCLES + 6 * NUM_MAPPED + 1
                                  + UNMAPPED_TRIES * (READ_SWEEP + 2)
                                  + NUM_SEG * (SEG_LEN + READ_SWEEP) + MARGIN;

    localparam logic [7:0] TIMER_BASE = ss_timer_pkg::SS_ADDR_TIMER_BASE;
    localparam logic [7:0] FLAG_ADDR  = TIMER_BASE + 8'(NUM_TIMERS);

    logic                       clk;
    logic                       arst_n;
    logic                       clk_32k_en;
    logic [NUM_TIMERS-1:0]      timer_enable;
    logic [NUM_TIMERS-1:0]      timer_clock_sel;
    logic [NUM_TIMERS-1:0][7:0] timer_reload;
    logic [NUM_TIMERS-1:0]      factor_mask;
    logic                       factor_ack;
    logic [7:0]                 ss_addr;
    logic [31:0]                ss_wdata;
    logic                       ss_write;
    logic                       ss_load_defaults;
    logic                       irq;
    logic [31:0]                ss_rdata;

    // Reference model state
    logic [6:0]            m_div;
    logic [7:0]            m_c256;
    logic                  m_tickq;
    logic [7:0]            m_dc [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] m_flags;

    logic [31:0] lfsr;
    logic [31:0] rnd;
    int          n_checks;
    int          n_errors;
    int          cycle_count;

    timer_savestate_top #(
        .NUM_TIMERS (NUM_TIMERS)
    ) u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .clk_32k_en       (clk_32k_en),
        .timer_enable     (timer_enable),
        .timer_clock_sel  (timer_clock_sel),
        .timer_reload     (timer_reload),
        .factor_mask      (factor_mask),
        .factor_ack       (factor_ack),
        .ss_addr          (ss_addr),
        .ss_wdata         (ss_wdata),
        .ss_write         (ss_write),
        .ss_load_defaults (ss_load_defaults),
        .irq              (irq),
        .ss_rdata         (ss_rdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected read word from the model state
    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        logic [31:0] w;
        w = '0;
        if (addr == ss_timer_pkg::SS_ADDR_PRESCALER) begin
            w = {16'h0000, m_tickq, m_div, m_c256};
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (addr == TIMER_BASE + 8'(i)) begin
                w = {24'h00_0000, m_dc[i]};
            end
        end
        if (addr == FLAG_ADDR) begin
            w = {{(32 - NUM_TIMERS){1'b0}}, m_flags};
        end
        return w;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_model_defaults;
        m_div   = '0;
        m_c256  = '0;
        m_tickq = 1'b0;
        m_flags = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            m_dc[i] = 8'hFF;
        end
    endtask

    // One rising edge of the model
    // Defaults load beats a bus write, which beats counting
    task automatic step_model;
        logic                  t8;
        logic                  t256;
        logic [NUM_TIMERS-1:0] sel;
        logic [NUM_TIMERS-1:0] uf;
        t8   = clk_32k_en && (m_div[1:0] == 2'b11);
        t256 = clk_32k_en && (m_div == 7'd127);
        for (int i = 0; i < NUM_TIMERS; i++) begin
            sel[i] = timer_clock_sel[i] ? t256 : t8;
            uf[i]  = timer_enable[i] && sel[i] && (m_dc[i] == 8'd0);
        end
        if (ss_load_defaults) begin
            load_model_defaults();
        end else begin
            if (ss_write && (ss_addr == ss_timer_pkg::SS_ADDR_PRESCALER)) begin
                m_tickq = ss_wdata[15];
                m_div   = ss_wdata[14:8];
                m_c256  = ss_wdata[7:0];
            end else begin
                m_tickq = t256;
                if (clk_32k_en) begin
                    m_div = m_div + 7'd1;
                end
                if (t256) begin
                    m_c256 = m_c256 + 8'd1;
                end
            end
            for (int i = 0; i < NUM_TIMERS; i++) begin
                if (ss_write && (ss_addr == TIMER_BASE + 8'(i))) begin
                    m_dc[i] = ss_wdata[7:0];
                end else if (timer_enable[i] && sel[i]) begin
                    m_dc[i] = uf[i] ? timer_reload[i] : m_dc[i] - 8'd1;
                end
            end
            if (ss_write && (ss_addr == FLAG_ADDR)) begin
                m_flags = ss_wdata[NUM_TIMERS-1:0];
            end else if (factor_ack) begin
                m_flags = uf;
            end else begin
                m_flags = m_flags | uf;
            end
        end
    endtask

    // Inputs are set at the falling edge
    // Check, clock, then return at the next fall
    task automatic run_cycle;
        #1;
        check_eq(ss_rdata, expected_read(ss_addr), $sformatf("ss_rdata at addr %0d", ss_addr));
        check_eq({31'b0, irq}, {31'b0, |(m_flags & factor_mask)}, "irq");
        @(posedge clk);
        step_model();
        @(negedge clk);
    endtask

    task automatic quiet_inputs;
        clk_32k_en       = 1'b0;
        timer_enable     = '0;
        timer_clock_sel  = '0;
        factor_ack       = 1'b0;
        ss_write         = 1'b0;
        ss_load_defaults = 1'b0;
    endtask

    task automatic randomize_inputs;
        rnd             = take_bits(2);
        clk_32k_en      = (rnd[1:0] != 2'b00);
        rnd             = take_bits(NUM_TIMERS);
        timer_enable    = rnd[NUM_TIMERS-1:0];
        rnd             = take_bits(NUM_TIMERS);
        timer_clock_sel = rnd[NUM_TIMERS-1:0];
        for (int i = 0; i < NUM_TIMERS; i++) begin
            rnd             = take_bits(3);
            timer_reload[i] = {5'b0, rnd[2:0]};
        end
        rnd         = take_bits(NUM_TIMERS);
        factor_mask = rnd[NUM_TIMERS-1:0];
        rnd         = take_bits(3);
        factor_ack  = (rnd[2:0] == 3'b000);
        rnd         = take_bits(3);
        ss_addr     = {5'b0, rnd[2:0]};
        rnd         = take_bits(4);
        ss_write    = (rnd[3:0] == 4'h0);
        ss_wdata    = take_bits(32);
        // Small restored counts keep underflows frequent
        if ((ss_addr >= TIMER_BASE) && (ss_addr < FLAG_ADDR)) begin
            ss_wdata[7:4] = 4'h0;
        end
    endtask

    task automatic read_all;
        ss_write = 1'b0;
        for (int a = 0; a < READ_SWEEP; a++) begin
            ss_addr = 8'(a);
            run_cycle();
        end
    endtask

    task automatic check_defaults(input string when);
        logic [31:0] exp;
        quiet_inputs();
        // All flags unmasked so a stale flag shows on irq
        factor_mask = '1;
        for (int a = 0; a < NUM_MAPPED; a++) begin
            ss_addr = 8'(a);
            exp     = ((ss_addr >= TIMER_BASE) && (ss_addr < FLAG_ADDR)) ? 32'hFF : 32'h0;
            #1;
            check_eq(ss_rdata, exp, $sformatf("default at addr %0d %s", a, when));
            check_eq({31'b0, irq}, 32'h0, $sformatf("irq %s", when));
            run_cycle();
        end
    endtask

    // Counters frozen so each word reads back through its own view
    task automatic write_readback;
        logic [31:0] mask;
        quiet_inputs();
        for (int a = 0; a < NUM_MAPPED; a++) begin
            ss_addr  = 8'(a);
            ss_wdata = take_bits(32);
            ss_write = 1'b1;
            if (ss_addr == ss_timer_pkg::SS_ADDR_PRESCALER) begin
                mask = 32'h0000_FFFF;
            end else if (ss_addr == FLAG_ADDR) begin
                mask = {{(32 - NUM_TIMERS){1'b0}}, {NUM_TIMERS{1'b1}}};
            end else begin
                mask = 32'h0000_00FF;
            end
            run_cycle();
            ss_write = 1'b0;
            #1;
            check_eq(ss_rdata, ss_wdata & mask, $sformatf("readback at addr %0d", a));
            run_cycle();
        end
    endtask

    task automatic unmapped_writes;
        logic [7:0] a;
        for (int n = 0; n < UNMAPPED_TRIES; n++) begin
            rnd = take_bits(8);
            a   = rnd[7:0];
            if (a <= FLAG_ADDR) begin
                a = a + FLAG_ADDR + 8'd1;
            end
            ss_addr  = a;
            ss_wdata = take_bits(32);
            ss_write = 1'b1;
            run_cycle();
            ss_write = 1'b0;
            #1;
            check_eq(ss_rdata, 32'h0, $sformatf("unmapped read at addr %0d", a));
            run_cycle();
            read_all();
        end
    endtask

    initial begin
        clk              = 1'b0;
        arst_n           = 1'b0;
        timer_reload     = '0;
        factor_mask      = '0;
        ss_addr          = '0;
        ss_wdata         = '0;
        quiet_inputs();
        lfsr        = 32'h4b4d4be9;
        n_checks    = 0;
        n_errors    = 0;
        cycle_count = 0;
        load_model_defaults();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_defaults("after reset");
        write_readback();
        unmapped_writes();

        for (int seg = 0; seg < NUM_SEG; seg++) begin
            for (int c = 0; c < SEG_LEN; c++) begin
                randomize_inputs();
                run_cycle();
            end
            read_all();
            if (seg == NUM_SEG / 2) begin
                // Defaults load wins even over a write to a mapped block
                randomize_inputs();
                ss_addr          = ss_addr % 8'(NUM_MAPPED);
                ss_load_defaults = 1'b1;
                ss_write         = 1'b1;
                run_cycle();
                check_defaults("after load defaults");
            end
        end

        $display("Checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src/timer_savestate_top.sv ====
`timescale 1ns/1ps

module timer_savestate_top #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  clk_32k_en,
    input  logic [NUM_TIMERS-1:0]                 timer_enable,
    input  logic [NUM_TIMERS-1:0]                 timer_clock_sel,
    input  logic [NUM_TIMERS-1:0][7:0]            timer_reload,
    input  logic [NUM_TIMERS-1:0]                 factor_mask,
    input  logic                                  factor_ack,
    input  logic [ss_timer_pkg::SS_ADDR_W-1:0]    ss_addr,
    input  logic [ss_timer_pkg::SS_DATA_W-1:0]    ss_wdata,
    input  logic                                  ss_write,
    input  logic                                  ss_load_defaults,
    output logic                                  irq,
    output logic [ss_timer_pkg::SS_DATA_W-1:0]    ss_rdata
);

    localparam int ADDR_W = ss_timer_pkg::SS_ADDR_W;
    localparam int DATA_W = ss_timer_pkg::SS_DATA_W;

    logic                               tick_8k;
    logic                               tick_256;
    logic [NUM_TIMERS-1:0]              underflow;
    logic [DATA_W-1:0]                  prescaler_word;
    logic [NUM_TIMERS-1:0][DATA_W-1:0]  timer_words;

    clock_prescaler u_prescaler (
        .clk              (clk),
        .arst_n           (arst_n),
        .clk_32k_en       (clk_32k_en),
        .ss_addr          (ss_addr),
        .ss_wdata         (ss_wdata),
        .ss_write         (ss_write),
        .ss_load_defaults (ss_load_defaults),
        .tick_8k          (tick_8k),
        .tick_256         (tick_256),
        .ss_word          (prescaler_word)
    );

    // One save-state slot per timer, in index order
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        prog_timer #(
            .SS_ADDR (ss_timer_pkg::SS_ADDR_TIMER_BASE + ADDR_W'(i))
        ) u_timer (
            .clk              (clk),
            .arst_n           (arst_n),
            .enable           (timer_enable[i]),
            .clock_sel        (timer_clock_sel[i]),
            .reload           (timer_reload[i]),
            .tick_8k          (tick_8k),
            .tick_256         (tick_256),
            .ss_addr          (ss_addr),
            .ss_wdata         (ss_wdata),
            .ss_write         (ss_write),
            .ss_load_defaults (ss_load_defaults),
            .underflow        (underflow[i]),
            .ss_word          (timer_words[i])
        );
    end

    interrupt_collector #(
        .NUM_TIMERS (NUM_TIMERS)
    ) u_collector (
        .clk              (clk),
        .arst_n           (arst_n),
        .underflow        (underflow),
        .factor_mask      (factor_mask),
        .factor_ack       (factor_ack),
        .ss_addr          (ss_addr),
        .ss_wdata         (ss_wdata),
        .ss_write         (ss_write),
        .ss_load_defaults (ss_load_defaults),
        .prescaler_word   (prescaler_word),
        .timer_words      (timer_words),
        .irq              (irq),
        .ss_rdata         (ss_rdata)
    );

endmodule

// ==== src/interrupt_collector.sv ====
`timescale 1ns/1ps

module interrupt_collector #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  logic [NUM_TIMERS-1:0]                                 underflow,
    input  logic [NUM_TIMERS-1:0]                                 factor_mask,
    input  logic                                                  factor_ack,
    input  logic [ss_timer_pkg::SS_ADDR_W-1:0]                    ss_addr,
    input  logic [ss_timer_pkg::SS_DATA_W-1:0]                    ss_wdata,
    input  logic                                                  ss_write,
    input  logic                                                  ss_load_defaults,
    input  logic [ss_timer_pkg::SS_DATA_W-1:0]                    prescaler_word,
    input  logic [NUM_TIMERS-1:0][ss_timer_pkg::SS_DATA_W-1:0]    timer_words,
    output logic                                                  irq,
    output logic [ss_timer_pkg::SS_DATA_W-1:0]                    ss_rdata
);

    localparam int ADDR_W = ss_timer_pkg::SS_ADDR_W;
    localparam int DATA_W = ss_timer_pkg::SS_DATA_W;

    // Flag word sits right after the last timer
    localparam logic [ADDR_W-1:0] FLAG_ADDR =
        ss_timer_pkg::SS_ADDR_TIMER_BASE + ADDR_W'(NUM_TIMERS);

    logic [NUM_TIMERS-1:0] flags;
    logic [DATA_W-1:0]     flag_word;
    logic                  flag_hit;

    assign flag_hit  = ss_write && (ss_addr == FLAG_ADDR);
    assign flag_word = {{(DATA_W - NUM_TIMERS){1'b0}}, flags};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (ss_load_defaults) begin
            flags <= '0;
        end else if (flag_hit) begin
            flags <= ss_wdata[NUM_TIMERS-1:0];
        end else if (factor_ack) begin
            // An underflow in the ack cycle survives the clear
            flags <= underflow;
        end else begin
            flags <= flags | underflow;
        end
    end

    assign irq = |(flags & factor_mask);

    // Read mux, unmapped addresses give zero
    always_comb begin
        ss_rdata = '0;
        if (ss_addr == ss_timer_pkg::SS_ADDR_PRESCALER) begin
            ss_rdata = prescaler_word;
        end
        if (ss_addr == FLAG_ADDR) begin
            ss_rdata = flag_word;
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (ss_addr == ss_timer_pkg::SS_ADDR_TIMER_BASE + ADDR_W'(i)) begin
                ss_rdata = timer_words[i];
            end
        end
    end

    a_irq_has_source: assert property (
        @(posedge clk) disable iff (!arst_n)
        irq |-> ((flags & factor_mask) != '0)
    );

    // Timer underflow is latched on the same edge, ack or not
    a_flag_latched: assert property (
        @(posedge clk) disable iff (!arst_n)
        ((underflow != '0) && !flag_hit && !ss_load_defaults)
            |=> ((flags & $past(underflow)) == $past(underflow))
    );

endmodule

// ==== src/prog_timer.sv ====
`timescale 1ns/1ps

module prog_timer #(
    parameter logic [ss_timer_pkg::SS_ADDR_W-1:0] SS_ADDR = ss_timer_pkg::SS_ADDR_TIMER_BASE
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  enable,
    input  logic                                  clock_sel,
    input  logic [7:0]                            reload,
    input  logic                                  tick_8k,
    input  logic                                  tick_256,
    input  logic [ss_timer_pkg::SS_ADDR_W-1:0]    ss_addr,
    input  logic [ss_timer_pkg::SS_DATA_W-1:0]    ss_wdata,
    input  logic                                  ss_write,
    input  logic                                  ss_load_defaults,
    output logic                                  underflow,
    output logic [ss_timer_pkg::SS_DATA_W-1:0]    ss_word
);

    logic [7:0]             downcounter;
    logic                   tick_sel;
    logic                   ss_hit;
    ss_timer_pkg::ss_word_u wr_word;
    ss_timer_pkg::ss_word_u rd_word;

    assign wr_word = ss_wdata;
    assign ss_hit  = ss_write && (ss_addr == SS_ADDR);

    // 0 picks 8 kHz, 1 picks 256 Hz
    assign tick_sel = clock_sel ? tick_256 : tick_8k;

    // Pulses on the tick that finds the count at zero
    assign underflow = enable && tick_sel && (downcounter == 8'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            downcounter <= ss_timer_pkg::DOWNCOUNTER_DEFAULT;
        end else if (ss_load_defaults) begin
            downcounter <= ss_timer_pkg::DOWNCOUNTER_DEFAULT;
        end else if (ss_hit) begin
            // A restore beats a tick in the same cycle
            downcounter <= wr_word.timer.downcounter;
        end else if (enable && tick_sel) begin
            if (underflow) begin
                downcounter <= reload;
            end else begin
                downcounter <= downcounter - 8'd1;
            end
        end
    end

    always_comb begin
        rd_word                   = '0;
        rd_word.timer.downcounter = downcounter;
    end

    assign ss_word = rd_word;

    // A stopped timer keeps its count unless the bus touches it
    a_hold_when_disabled: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!enable && !ss_hit && !ss_load_defaults) |=> $stable(downcounter)
    );

    // Underflow only from zero, and the next count is the reload value
    a_underflow_reload: assert property (
        @(posedge clk) disable iff (!arst_n)
        (underflow && !ss_hit && !ss_load_defaults)
            |-> (downcounter == 8'd0) ##1 (downcounter == $past(reload))
    );

endmodule

// ==== src/clock_prescaler.sv ====
`timescale 1ns/1ps

module clock_prescaler (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  clk_32k_en,
    input  logic [ss_timer_pkg::SS_ADDR_W-1:0]    ss_addr,
    input  logic [ss_timer_pkg::SS_DATA_W-1:0]    ss_wdata,
    input  logic                                  ss_write,
    input  logic                                  ss_load_defaults,
    output logic                                  tick_8k,
    output logic                                  tick_256,
    output logic [ss_timer_pkg::SS_DATA_W-1:0]    ss_word
);

    logic [6:0]             divider;
    logic [7:0]             counter_256;
    logic                   tick_256_q;
    logic                   ss_hit;
    ss_timer_pkg::ss_word_u wr_word;
    ss_timer_pkg::ss_word_u rd_word;

    assign wr_word = ss_wdata;
    assign ss_hit  = ss_write && (ss_addr == ss_timer_pkg::SS_ADDR_PRESCALER);

    // 32 kHz / 4 and 32 kHz / 128
    assign tick_8k  = clk_32k_en && (divider[1:0] == 2'b11);
    assign tick_256 = clk_32k_en && (divider == 7'd127);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            divider     <= '0;
            counter_256 <= '0;
            tick_256_q  <= 1'b0;
        end else if (ss_load_defaults) begin
            divider     <= '0;
            counter_256 <= '0;
            tick_256_q  <= 1'b0;
        end else if (ss_hit) begin
            divider     <= wr_word.prescaler.divider;
            counter_256 <= wr_word.prescaler.counter_256;
            tick_256_q  <= wr_word.prescaler.tick_256;
        end else begin
            // Tick bit follows the wrap by one cycle
            tick_256_q <= tick_256;
            if (clk_32k_en) begin
                divider <= divider + 7'd1;
            end
            if (tick_256) begin
                counter_256 <= counter_256 + 8'd1;
            end
        end
    end

    // Padding reads back as zero
    always_comb begin
        rd_word                       = '0;
        rd_word.prescaler.tick_256    = tick_256_q;
        rd_word.prescaler.divider     = divider;
        rd_word.prescaler.counter_256 = counter_256;
    end

    assign ss_word = rd_word;

    // Every 256 Hz tick must land on an 8 kHz tick, or the timers drift apart
    a_tick_nested: assert property (
        @(posedge clk) disable iff (!arst_n)
        tick_256 |-> tick_8k
    );

endmodule

// ==== src/ss_timer_pkg.sv ====
package ss_timer_pkg;

    // Save-state bus widths
    localparam int SS_ADDR_W = 8;
    localparam int SS_DATA_W = 32;

    // Address map, timer i sits at SS_ADDR_TIMER_BASE + i
    localparam logic [SS_ADDR_W-1:0] SS_ADDR_PRESCALER = 8'h00;
    localparam logic [SS_ADDR_W-1:0] SS_ADDR_TIMER_BASE = 8'h01;

    // Value loaded into every down-counter on reset and on defaults load
    localparam logic [7:0] DOWNCOUNTER_DEFAULT = 8'hFF;

    // One save-state word, read either as the prescaler or as a timer
    typedef union packed {
        struct packed {
            logic [15:0] pad;
            logic        tick_256;
            logic [6:0]  divider;
            logic [7:0]  counter_256;
        } prescaler;
        struct packed {
            logic [23:0] pad;
            logic [7:0]  downcounter;
        } timer;
    } ss_word_u;

endpackage
